// ==== common/glue_pkg.sv ====
/* shared constants and types for the core glue block
   the design is fixed at a 125 MHz clock and 48 kHz 16-bit stereo I2S */
package glue_pkg;

	// clocking and audio rates
	localparam int unsigned sys_clk_hz = 125_000_000;
	localparam int unsigned i2s_sample_hz = 48_000;
	localparam int audio_dw = 16;
	// two channels, audio_dw bits each, two bit_ce per bck period
	localparam int unsigned i2s_step = i2s_sample_hz * 2 * audio_dw * 2;

	// reset sequencer
	localparam int reset_cnt_w = 16;
	typedef logic [reset_cnt_w-1:0] reset_count;
	localparam reset_count por_load = '1;
	localparam reset_count soft_load = 16'd4095;

	// menu status word and joysticks
	localparam int status_w = 64;
	localparam int joy_w = 11;

	typedef logic [status_w-1:0] status_word;
	typedef logic [joy_w-1:0] joy_state;
	typedef logic [15:0] joy_raw;
	typedef logic signed [audio_dw-1:0] audio_sample;
	typedef logic [4:0] i2s_bit_index;

	typedef enum logic [1:0] {
		sl_off,
		sl_25,
		sl_50,
		sl_75
	} scanline_mode;

	// status field positions
	// scanlines take two bits upward from st_scanlines_lo
	localparam int st_reset = 0;
	localparam int st_scanlines_lo = 3;
	localparam int st_blend = 5;
	localparam int st_joyswap = 6;
	localparam int st_userport = 7;
	localparam int st_invtape = 8;

endpackage

// ==== rtl/core_controls.sv ====
/* core reset sequencer, menu option decoding and joystick swap
   all outputs are registered, options lag the status word by one cycle */
`timescale 1ns/1ps

module core_controls (
	input  logic                     clk,
	input  logic                     pll_locked,
	input  glue_pkg::status_word     status,
	input  logic [1:0]               buttons,
	input  logic                     soft_reset_req,
	input  logic                     hard_reset_req,
	input  glue_pkg::joy_raw         joy0,
	input  glue_pkg::joy_raw         joy1,
	output logic                     core_reset,
	output glue_pkg::scanline_mode   scanlines,
	output logic                     blend,
	output logic                     userport,
	output logic                     invert_tape,
	output glue_pkg::joy_state       joy_left,
	output glue_pkg::joy_state       joy_right
);

	glue_pkg::reset_count reset_cnt;
	logic reset_req;
	logic joyswap;

	// any source restarts the short count
	assign reset_req = status[glue_pkg::st_reset] | buttons[1] |
		soft_reset_req | hard_reset_req;

	assign joyswap = status[glue_pkg::st_joyswap];

	// long count after power-up, short reload on a request
	always_ff @(posedge clk or negedge pll_locked) begin
		if (!pll_locked) begin
			reset_cnt <= glue_pkg::por_load;
			core_reset <= 1'b1;
		end else begin
			if (reset_req)
				reset_cnt <= glue_pkg::soft_load;
			else if (reset_cnt != '0)
				reset_cnt <= reset_cnt - 1'b1;
			core_reset <= (reset_cnt != '0);
		end
	end

	// option fields and joystick pair
	always_ff @(posedge clk or negedge pll_locked) begin
		if (!pll_locked) begin
			scanlines <= glue_pkg::sl_off;
			blend <= 1'b0;
			userport <= 1'b0;
			invert_tape <= 1'b0;
			joy_left <= '0;
			joy_right <= '0;
		end else begin
			scanlines <= glue_pkg::scanline_mode'(status[glue_pkg::st_scanlines_lo +: 2]);
			blend <= status[glue_pkg::st_blend];
			userport <= status[glue_pkg::st_userport];
			invert_tape <= status[glue_pkg::st_invtape];
			// joy1 is the left port unless swapped
			joy_left <= joyswap ? joy0[glue_pkg::joy_w-1:0] : joy1[glue_pkg::joy_w-1:0];
			joy_right <= joyswap ? joy1[glue_pkg::joy_w-1:0] : joy0[glue_pkg::joy_w-1:0];
		end
	end

endmodule

// ==== rtl/userport_router.sv ====
/* routes the serial receive pin to the core UART or the tape input
   uart_rx is asynchronous and passes a two-flop synchronizer first */
`timescale 1ns/1ps

module userport_router (
	input  logic clk,
	input  logic pll_locked,
	input  logic uart_rx,
	input  logic core_uart_tx,
	input  logic userport,
	input  logic invert_tape,
	output logic core_uart_rx,
	output logic uart_tx,
	output logic ear_in
);

	logic rx_meta;
	logic rx_sync;

	// idle line level is high
	always_ff @(posedge clk or negedge pll_locked) begin
		if (!pll_locked) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= uart_rx;
			rx_sync <= rx_meta;
		end
	end

	// userport mode owns both pins, otherwise rx feeds the tape
	assign core_uart_rx = userport ? rx_sync : 1'b0;
	assign uart_tx = userport ? core_uart_tx : 1'b1;
	assign ear_in = userport ? 1'b0 : (rx_sync ^ invert_tape);

endmodule

// ==== i2s/i2s_rate_gen.sv ====
/* fractional bit clock enable for the I2S master
   pulses twice per bck period, spacing alternates between 40 and 41 clocks */
`timescale 1ns/1ps

module i2s_rate_gen (
	input  logic clk,
	input  logic pll_locked,
	output logic bit_ce
);

	logic [31:0] acc;
	logic [31:0] acc_next;

	assign acc_next = acc + glue_pkg::i2s_step;

	// phase wraps at the clock rate without losing the remainder
	always_ff @(posedge clk or negedge pll_locked) begin
		if (!pll_locked) begin
			acc <= '0;
			bit_ce <= 1'b0;
		end else if (acc_next >= glue_pkg::sys_clk_hz) begin
			acc <= acc_next - glue_pkg::sys_clk_hz;
			bit_ce <= 1'b1;
		end else begin
			acc <= acc_next;
			bit_ce <= 1'b0;
		end
	end

endmodule

// ==== i2s/i2s_serializer.sv ====
/* standard I2S shifter, MSB first with a one-bit delay after lrck
   the stereo pair is sampled once per frame when lrck falls */
`timescale 1ns/1ps

module i2s_serializer (
	input  logic                    clk,
	input  logic                    pll_locked,
	input  logic                    bit_ce,
	input  glue_pkg::audio_sample   left_chan,
	input  glue_pkg::audio_sample   right_chan,
	output logic                    i2s_bck,
	output logic                    i2s_lrck,
	output logic                    i2s_data
);

	glue_pkg::i2s_bit_index bit_cnt;
	glue_pkg::audio_sample left_q;
	glue_pkg::audio_sample right_q;
	logic [3:0] bit_sel;
	logic bck_fall;

	// bit 1 selects the MSB
	assign bit_sel = 4'(glue_pkg::audio_dw - bit_cnt);
	assign bck_fall = bit_ce & i2s_bck;

	always_ff @(posedge clk or negedge pll_locked) begin
		if (!pll_locked) begin
			bit_cnt <= 5'd1;
			i2s_bck <= 1'b1;
			i2s_lrck <= 1'b1;
			i2s_data <= 1'b1;
		end else begin
			if (bit_ce)
				i2s_bck <= ~i2s_bck;
			if (bck_fall) begin
				if (bit_cnt == glue_pkg::i2s_bit_index'(glue_pkg::audio_dw)) begin
					bit_cnt <= 5'd1;
					i2s_lrck <= ~i2s_lrck;
				end else begin
					bit_cnt <= bit_cnt + 5'd1;
				end
				// old lrck and index give the one-bit delay
				i2s_data <= i2s_lrck ? right_q[bit_sel] : left_q[bit_sel];
			end
		end
	end

	// latch both channels as lrck goes low
	always_ff @(posedge clk or negedge pll_locked) begin
		if (!pll_locked) begin
			left_q <= '0;
			right_q <= '0;
		end else if (bck_fall && i2s_lrck &&
			bit_cnt == glue_pkg::i2s_bit_index'(glue_pkg::audio_dw)) begin
			left_q <= left_chan;
			right_q <= right_chan;
		end
	end

endmodule

// ==== rtl/core_glue_top.sv ====
/* glue logic around the computer core: reset, options, userport and I2S
   single 125 MHz clock domain, uart_rx is the only asynchronous input */
`timescale 1ns/1ps

module core_glue_top (
	input  logic                     clk,
	input  logic                     pll_locked,
	input  glue_pkg::status_word     status,
	input  logic [1:0]               buttons,
	input  logic                     soft_reset_req,
	input  logic                     hard_reset_req,
	input  glue_pkg::joy_raw         joy0,
	input  glue_pkg::joy_raw         joy1,
	input  logic                     uart_rx,
	input  logic                     core_uart_tx,
	input  glue_pkg::audio_sample    left_chan,
	input  glue_pkg::audio_sample    right_chan,
	output logic                     core_reset,
	output glue_pkg::scanline_mode   scanlines,
	output logic                     blend,
	output glue_pkg::joy_state       joy_left,
	output glue_pkg::joy_state       joy_right,
	output logic                     core_uart_rx,
	output logic                     uart_tx,
	output logic                     ear_in,
	output logic                     i2s_bck,
	output logic                     i2s_lrck,
	output logic                     i2s_data
);

	// decoded option bits for the userport
	logic userport;
	logic invert_tape;

	// one-cycle bit clock enable
	logic bit_ce;

	core_controls controls_i (
		.clk            (clk),
		.pll_locked     (pll_locked),
		.status         (status),
		.buttons        (buttons),
		.soft_reset_req (soft_reset_req),
		.hard_reset_req (hard_reset_req),
		.joy0           (joy0),
		.joy1           (joy1),
		.core_reset     (core_reset),
		.scanlines      (scanlines),
		.blend          (blend),
		.userport       (userport),
		.invert_tape    (invert_tape),
		.joy_left       (joy_left),
		.joy_right      (joy_right)
	);

	userport_router router_i (
		.clk          (clk),
		.pll_locked   (pll_locked),
		.uart_rx      (uart_rx),
		.core_uart_tx (core_uart_tx),
		.userport     (userport),
		.invert_tape  (invert_tape),
		.core_uart_rx (core_uart_rx),
		.uart_tx      (uart_tx),
		.ear_in       (ear_in)
	);

	i2s_rate_gen rate_gen_i (
		.clk        (clk),
		.pll_locked (pll_locked),
		.bit_ce     (bit_ce)
	);

	i2s_serializer serializer_i (
		.clk        (clk),
		.pll_locked (pll_locked),
		.bit_ce     (bit_ce),
		.left_chan  (left_chan),
		.right_chan (right_chan),
		.i2s_bck    (i2s_bck),
		.i2s_lrck   (i2s_lrck),
		.i2s_data   (i2s_data)
	);

endmodule

// ==== dv/core_glue_props.sv ====
/* concurrent checks bound to every core_glue_top instance
   covers the reset output, lrck alignment and the idle transmit pin */
`timescale 1ns/1ps

module core_glue_props (
	input logic                 clk,
	input logic                 pll_locked,
	input glue_pkg::status_word status,
	input logic                 core_reset,
	input logic                 i2s_bck,
	input logic                 i2s_lrck,
	input logic                 uart_tx
);

	int unsigned fail_count = 0;

	// sampled on the falling edge between register updates
	reset_held: assert property (@(negedge clk) !pll_locked |-> core_reset)
		else begin
			fail_count = fail_count + 1;
			$error("core_reset is low while pll_locked is low");
		end

	// word select moves only together with a falling bit clock
	lrck_on_bck_fall: assert property (@(posedge clk) disable iff (!pll_locked)
		(i2s_lrck != $past(i2s_lrck)) |-> (!i2s_bck && $past(i2s_bck)))
		else begin
			fail_count = fail_count + 1;
			$error("i2s_lrck changed without a falling i2s_bck");
		end

	// userport bit clear for two samples means the option register is clear
	tx_idle: assert property (@(posedge clk) disable iff (!pll_locked)
		(!status[glue_pkg::st_userport] && !$past(status[glue_pkg::st_userport]))
		|-> uart_tx)
		else begin
			fail_count = fail_count + 1;
			$error("uart_tx is low outside userport mode");
		end

endmodule

bind core_glue_top core_glue_props props_i (
	.clk        (clk),
	.pll_locked (pll_locked),
	.status     (status),
	.core_reset (core_reset),
	.i2s_bck    (i2s_bck),
	.i2s_lrck   (i2s_lrck),
	.uart_tx    (uart_tx)
);

// ==== dv/core_glue_tb.sv ====
/* drives core_glue_top through reset lengths, option rows and I2S frames
   a full power-on count runs first, so the run takes about 170k cycles */
`timescale 1ns/1ps

module core_glue_tb;

	localparam int num_rows = 8;
	localparam int reset_timeout = 70000;
	localparam int i2s_timeout = 14000;

	typedef struct {
		glue_pkg::status_word status;
		glue_pkg::joy_raw joy0;
		glue_pkg::joy_raw joy1;
		logic uart_rx;
		logic core_uart_tx;
		glue_pkg::audio_sample left;
		glue_pkg::audio_sample right;
		glue_pkg::scanline_mode exp_scan;
		logic exp_blend;
		glue_pkg::joy_state exp_left;
		glue_pkg::joy_state exp_right;
		logic exp_core_rx;
		logic exp_tx;
		logic exp_ear;
	} stim_row;

	logic clk = 1'b0;
	logic pll_locked;
	glue_pkg::status_word status;
	logic [1:0] buttons;
	logic soft_reset_req;
	logic hard_reset_req;
	glue_pkg::joy_raw joy0;
	glue_pkg::joy_raw joy1;
	logic uart_rx;
	logic core_uart_tx;
	glue_pkg::audio_sample left_chan;
	glue_pkg::audio_sample right_chan;
	logic core_reset;
	glue_pkg::scanline_mode scanlines;
	logic blend;
	glue_pkg::joy_state joy_left;
	glue_pkg::joy_state joy_right;
	logic core_uart_rx;
	logic uart_tx;
	logic ear_in;
	logic i2s_bck;
	logic i2s_lrck;
	logic i2s_data;

	stim_row rows [num_rows];
	logic [31:0] lfsr_state;
	int edges;

	core_glue_top dut_i (.*);

	always #4 clk = ~clk;

	task automatic abort_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_mode(input string name, input glue_pkg::scanline_mode got,
			input glue_pkg::scanline_mode exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %s (%b), expected %s (%b)", $time, name,
				got.name(), got, exp.name(), exp);
			abort_run();
		end
	endtask

	task automatic check_joy(input string name, input glue_pkg::joy_state got,
			input glue_pkg::joy_state exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_sample(input string name, input glue_pkg::audio_sample got,
			input glue_pkg::audio_sample exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	// one frame is 2 channels of audio_dw bck periods with two bit enables each
	task automatic check_period(input int got);
		longint lo;
		lo = (longint'(glue_pkg::sys_clk_hz) * 4 * glue_pkg::audio_dw) / glue_pkg::i2s_step;
		if (got < lo || got > lo + 1) begin
			$display("Error at %0t ns: lrck period is %0d, expected %0d or %0d", $time,
				got, lo, lo + 1);
			abort_run();
		end
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		else
			return s >> 1;
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[62:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// opt is {invtape, userport, joyswap, blend, scanlines}
	// pins are {uart_rx, core_uart_tx}
	task automatic build_table();
		logic [5:0] opt_tab [num_rows] = '{6'b000000, 6'b001101, 6'b100010, 6'b101111,
			6'b010100, 6'b111001, 6'b110110, 6'b001011};
		logic [1:0] pin_tab [num_rows] = '{2'b10, 2'b01, 2'b10, 2'b01,
			2'b10, 2'b01, 2'b00, 2'b11};
		logic [63:0] rnd;
		logic [5:0] opt;
		for (int r = 0; r < num_rows; r++) begin
			opt = opt_tab[r];
			rnd = rand_bits(57);
			// bit 0 stays clear so the rows never request a reset
			rows[r].status = {rnd[56:2], opt, rnd[1:0], 1'b0};
			rows[r].joy0 = glue_pkg::joy_raw'(rand_bits(16));
			rows[r].joy1 = glue_pkg::joy_raw'(rand_bits(16));
			rows[r].left = glue_pkg::audio_sample'(rand_bits(16));
			rows[r].right = glue_pkg::audio_sample'(rand_bits(16));
			rows[r].uart_rx = pin_tab[r][1];
			rows[r].core_uart_tx = pin_tab[r][0];
			rows[r].exp_scan = glue_pkg::scanline_mode'(opt[1:0]);
			rows[r].exp_blend = opt[2];
			rows[r].exp_left = opt[3] ? rows[r].joy0[10:0] : rows[r].joy1[10:0];
			rows[r].exp_right = opt[3] ? rows[r].joy1[10:0] : rows[r].joy0[10:0];
			rows[r].exp_core_rx = opt[4] ? pin_tab[r][1] : 1'b0;
			rows[r].exp_tx = opt[4] ? pin_tab[r][0] : 1'b1;
			rows[r].exp_ear = opt[4] ? 1'b0 : (pin_tab[r][1] ^ opt[5]);
		end
	endtask

	// edges until core_reset has been high and drops again
	task automatic count_reset_edges(output int n);
		logic seen_high;
		logic done;
		seen_high = core_reset;
		done = 1'b0;
		n = 0;
		while (!done) begin
			@(negedge clk);
			n++;
			if (core_reset)
				seen_high = 1'b1;
			else if (seen_high)
				done = 1'b1;
			if (!done && n > reset_timeout) begin
				$display("Timeout: core_reset did not fall within %0d cycles", reset_timeout);
				abort_run();
			end
		end
	endtask

	// counter needs load edges to reach zero and the output follows one edge later
	task automatic pulse_request(input int src);
		int n;
		@(negedge clk);
		case (src)
			0: soft_reset_req = 1'b1;
			1: hard_reset_req = 1'b1;
			2: buttons[1] = 1'b1;
			default: status[glue_pkg::st_reset] = 1'b1;
		endcase
		@(negedge clk);
		soft_reset_req = 1'b0;
		hard_reset_req = 1'b0;
		buttons = '0;
		status[glue_pkg::st_reset] = 1'b0;
		count_reset_edges(n);
		check_count("reset length after request", n, int'(glue_pkg::soft_load) + 1);
	endtask

	// captures three frames latched after the samples were applied
	task automatic check_i2s_frames(input glue_pkg::audio_sample exp_l,
			input glue_pkg::audio_sample exp_r);
		logic prev_bck;
		logic prev_lrck;
		logic active;
		logic word_ch;
		glue_pkg::audio_sample shreg;
		int rise_cnt;
		int nbits;
		int words;
		int falls;
		int period;
		int guard;
		prev_bck = i2s_bck;
		prev_lrck = i2s_lrck;
		active = 1'b0;
		word_ch = 1'b0;
		shreg = '0;
		rise_cnt = 3;
		nbits = 0;
		words = 0;
		falls = 0;
		period = 0;
		guard = 0;
		while (words < 6) begin
			@(negedge clk);
			guard++;
			period++;
			if (guard > i2s_timeout) begin
				$display("Timeout: fewer than six I2S words within %0d cycles", i2s_timeout);
				abort_run();
			end
			if (prev_lrck && !i2s_lrck) begin
				falls++;
				if (falls > 1)
					check_period(period);
				period = 0;
			end
			if (i2s_lrck != prev_lrck)
				rise_cnt = 0;
			if (i2s_bck && !prev_bck) begin
				rise_cnt++;
				// the MSB sits on the second rising bck after the one-bit delay
				if (rise_cnt == 2 && falls >= 1) begin
					active = 1'b1;
					nbits = 0;
					word_ch = i2s_lrck;
				end
				if (active) begin
					shreg = {shreg[14:0], i2s_data};
					nbits++;
					if (nbits == glue_pkg::audio_dw) begin
						active = 1'b0;
						check_bit("lrck at word start", word_ch, words[0]);
						check_sample(word_ch ? "right word" : "left word", shreg,
							word_ch ? exp_r : exp_l);
						words++;
					end
				end
			end
			prev_bck = i2s_bck;
			prev_lrck = i2s_lrck;
		end
	endtask

	task automatic apply_row(input int r);
		@(negedge clk);
		status = rows[r].status;
		joy0 = rows[r].joy0;
		joy1 = rows[r].joy1;
		uart_rx = rows[r].uart_rx;
		core_uart_tx = rows[r].core_uart_tx;
		left_chan = rows[r].left;
		right_chan = rows[r].right;
		@(negedge clk);
		check_mode("scanlines", scanlines, rows[r].exp_scan);
		check_bit("blend", blend, rows[r].exp_blend);
		check_joy("joy_left", joy_left, rows[r].exp_left);
		check_joy("joy_right", joy_right, rows[r].exp_right);
		// receive pin needs two edges through the synchronizer
		@(negedge clk);
		check_bit("core_uart_rx", core_uart_rx, rows[r].exp_core_rx);
		check_bit("uart_tx", uart_tx, rows[r].exp_tx);
		check_bit("ear_in", ear_in, rows[r].exp_ear);
		check_i2s_frames(rows[r].left, rows[r].right);
	endtask

	initial begin
		pll_locked = 1'b0;
		status = '0;
		buttons = '0;
		soft_reset_req = 1'b0;
		hard_reset_req = 1'b0;
		joy0 = '0;
		joy1 = '0;
		uart_rx = 1'b1;
		core_uart_tx = 1'b1;
		left_chan = '0;
		right_chan = '0;
		lfsr_state = 32'hafd0;
		build_table();
		repeat (16) @(negedge clk);
		pll_locked = 1'b1;
		check_bit("core_reset", core_reset, 1'b1);
		count_reset_edges(edges);
		check_count("power-on reset length", edges, int'(glue_pkg::por_load) + 1);
		for (int src = 0; src < 4; src++)
			pulse_request(src);
		for (int r = 0; r < num_rows; r++)
			apply_row(r);
		@(negedge clk);
		if (dut_i.props_i.fail_count == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("*** TEST FAILED ***");
			$fatal(1, "bound assertions failed %0d times", dut_i.props_i.fail_count);
		end
	end

endmodule

// ==== core_glue.f ====
common/glue_pkg.sv
rtl/core_controls.sv
rtl/userport_router.sv
i2s/i2s_rate_gen.sv
i2s/i2s_serializer.sv
rtl/core_glue_top.sv
dv/core_glue_props.sv
dv/core_glue_tb.sv
